// ==== project.f ====
+incdir+.
simd_alu_pkg.sv
simd_alu_decode.sv
simd_alu_addsub.sv
simd_alu_compare.sv
simd_alu_shift.sv
simd_alu_execute.sv
simd_alu.sv
simd_alu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SIMD ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module simd_alu_tb -o simd_alu_sim
./obj_dir/simd_alu_sim | tee sim.log

if grep -q '^PASS: all tests$' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// ==== simd_alu.sv ====
// Two-stage packed-SIMD ALU. A strobed request returns exactly two
// cycles later. No back-pressure, every response must be taken.

`timescale 1ns/1ps

module simd_alu (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_valid_i,
  input  simd_alu_pkg::alu_req_t  req_i,
  output logic                    resp_valid_o,
  output simd_alu_pkg::alu_resp_t resp_o
);
  import simd_alu_pkg::*;

  logic      ex_valid;
  exec_req_t ex_req;

  simd_alu_decode u_decode (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .ex_valid_o  (ex_valid),
    .ex_req_o    (ex_req)
  );

  simd_alu_execute u_execute (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ex_valid_i   (ex_valid),
    .ex_req_i     (ex_req),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

endmodule

// ==== simd_alu_addsub.sv ====
// Lane adder for the SIMD ALU. Purely combinational.
// diff_o is only a true a-b when both sub flags are set.

`timescale 1ns/1ps

module simd_alu_addsub (
  input  simd_alu_pkg::exec_ctrl_t ctrl_i,
  input  simd_alu_pkg::word_t      op_a_i,
  input  simd_alu_pkg::word_t      op_b_i,
  output simd_alu_pkg::word_t      sum_o,
  output simd_alu_pkg::word_t      diff_o,
  output logic                     ov_o
);
  import simd_alu_pkg::*;

  word_t      b_route;
  word_t      wrap_res;
  word_t      half8, half16, sat8_res, sat16_res;
  lane_mask_t lane_sub;
  lane_mask_t ext;     // Sign/carry bit above each byte result
  lane_mask_t clamp;

  assign b_route  = ctrl_i.crossed ? {op_b_i[15:0], op_b_i[31:16]} : op_b_i;
  assign lane_sub = {ctrl_i.sub_hi, ctrl_i.sub_hi, ctrl_i.sub_lo, ctrl_i.sub_lo};

  //////////////////////////////////////////////////
  // Byte adders with split carry chain
  //////////////////////////////////////////////////
  always_comb begin
    logic       carry;
    logic       cin;
    byte_t      b_inv;
    logic [8:0] byte_sum;
    carry = 1'b0;
    for (int i = 0; i < 4; i++) begin
      b_inv = lane_sub[i] ? ~b_route[8*i +: 8] : b_route[8*i +: 8];
      // Odd bytes take the carry when lanes are 16 bits wide
      cin = ((i % 2 == 1) && !ctrl_i.width8) ? carry : lane_sub[i];
      byte_sum = {1'b0, op_a_i[8*i +: 8]} + {1'b0, b_inv} + 9'(cin);
      carry = byte_sum[8];
      wrap_res[8*i +: 8] = byte_sum[7:0];
      if (ctrl_i.is_signed) begin
        ext[i]   = op_a_i[8*i+7] ^ b_inv[7] ^ byte_sum[8];
        clamp[i] = ext[i] ^ byte_sum[7];
      end else begin
        // Unsigned sub borrows when there is no carry out
        ext[i]   = byte_sum[8] ^ lane_sub[i];
        clamp[i] = ext[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // Halving and saturation
  //////////////////////////////////////////////////
  always_comb begin
    byte_t lim8;
    half_t lim16;
    for (int i = 0; i < 4; i++) begin
      if (ctrl_i.is_signed) begin
        lim8 = ext[i] ? SAT_S8_MIN : SAT_S8_MAX;
      end else begin
        lim8 = lane_sub[i] ? '0 : SAT_U8_MAX;
      end
      half8[8*i +: 8]    = {ext[i], wrap_res[8*i+1 +: 7]};
      sat8_res[8*i +: 8] = clamp[i] ? lim8 : wrap_res[8*i +: 8];
    end
    // Halfword lanes use the flags of their upper byte
    for (int h = 0; h < 2; h++) begin
      if (ctrl_i.is_signed) begin
        lim16 = ext[2*h+1] ? SAT_S16_MIN : SAT_S16_MAX;
      end else begin
        lim16 = lane_sub[2*h+1] ? '0 : SAT_U16_MAX;
      end
      half16[16*h +: 16]    = {ext[2*h+1], wrap_res[16*h+1 +: 15]};
      sat16_res[16*h +: 16] = clamp[2*h+1] ? lim16 : wrap_res[16*h +: 16];
    end
  end

  always_comb begin
    unique case (ctrl_i.rmode)
      RM_HALVE: sum_o = ctrl_i.width8 ? half8 : half16;
      RM_SAT:   sum_o = ctrl_i.width8 ? sat8_res : sat16_res;
      default:  sum_o = wrap_res;
    endcase
  end

  assign diff_o = wrap_res;
  assign ov_o   = ctrl_i.width8 ? |clamp : (clamp[3] | clamp[1]);

endmodule

// ==== simd_alu_compare.sv ====
// Lane compare and min/max. Relies on diff_i being the wrapped a-b
// computed with the same lane width as ctrl_i.width8.

`timescale 1ns/1ps

module simd_alu_compare (
  input  simd_alu_pkg::exec_ctrl_t ctrl_i,
  input  simd_alu_pkg::word_t      op_a_i,
  input  simd_alu_pkg::word_t      op_b_i,
  input  simd_alu_pkg::word_t      diff_i,
  output simd_alu_pkg::word_t      cmp_o,
  output simd_alu_pkg::word_t      minmax_o
);
  import simd_alu_pkg::*;

  lane_mask_t byte_eq, byte_lt;
  lane_mask_t lane_eq, lane_lt;
  lane_mask_t mask;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      byte_eq[i] = (diff_i[8*i +: 8] == '0);
      // Same sign: difference sign decides, else the operand signs do
      if (op_a_i[8*i+7] == op_b_i[8*i+7]) begin
        byte_lt[i] = diff_i[8*i+7];
      end else begin
        byte_lt[i] = ctrl_i.is_signed ? op_a_i[8*i+7] : op_b_i[8*i+7];
      end
    end
  end

  assign lane_eq = ctrl_i.width8 ? byte_eq :
                   {{2{&byte_eq[3:2]}}, {2{&byte_eq[1:0]}}};
  assign lane_lt = ctrl_i.width8 ? byte_lt : {{2{byte_lt[3]}}, {2{byte_lt[1]}}};

  always_comb begin
    unique case (ctrl_i.cmp_kind)
      CMP_LT:  mask = lane_lt;
      CMP_LE:  mask = lane_lt | lane_eq;
      CMP_GT:  mask = ~(lane_lt | lane_eq);
      default: mask = lane_eq;
    endcase
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      cmp_o[8*i +: 8]    = {8{mask[i]}};
      minmax_o[8*i +: 8] = mask[i] ? op_a_i[8*i +: 8] : op_b_i[8*i +: 8];
    end
  end

endmodule

// ==== simd_alu_decode.sv ====
// Stage 1 of the SIMD ALU. Decodes one request per cycle, no stalls.
// Operands and controls only load on a valid strobe.

`timescale 1ns/1ps

module simd_alu_decode (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_valid_i,
  input  simd_alu_pkg::alu_req_t  req_i,
  output logic                    ex_valid_o,
  output simd_alu_pkg::exec_req_t ex_req_o
);
  import simd_alu_pkg::*;

  exec_ctrl_t ctrl;
  logic       is_pair;

  assign is_pair = req_i.op inside {OP_CRAS, OP_CRSA, OP_STAS, OP_STSA};

  always_comb begin
    ctrl            = '0;
    ctrl.width8     = (req_i.ltype == U8) || (req_i.ltype == S8);
    ctrl.is_signed  = (req_i.ltype == S8) || (req_i.ltype == S16);
    ctrl.rmode      = RM_WRAP;
    ctrl.result_sel = RES_SHIFT_PACK;
    ctrl.cmp_kind   = CMP_EQ;

    unique case (req_i.op)
      OP_ADD:  ctrl.result_sel = RES_ADD;
      OP_SUB: begin
        ctrl.sub_lo     = 1'b1;
        ctrl.sub_hi     = 1'b1;
        ctrl.result_sel = RES_ADD;
      end
      // Crossed pairs: b halves swap before the adder
      OP_CRAS, OP_CRSA: begin
        ctrl.crossed    = 1'b1;
        ctrl.sub_lo     = (req_i.op == OP_CRAS);
        ctrl.sub_hi     = (req_i.op == OP_CRSA);
        ctrl.result_sel = RES_ADD;
      end
      OP_STAS, OP_STSA: begin
        ctrl.sub_lo     = (req_i.op == OP_STAS);
        ctrl.sub_hi     = (req_i.op == OP_STSA);
        ctrl.result_sel = RES_ADD;
      end
      OP_CMPEQ, OP_CMPLT, OP_CMPLE, OP_MIN, OP_MAX: begin
        ctrl.sub_lo = 1'b1;
        ctrl.sub_hi = 1'b1;
        if (req_i.op inside {OP_MIN, OP_MAX}) begin
          ctrl.result_sel = RES_MINMAX;
        end else begin
          ctrl.result_sel = RES_CMP;
        end
        unique case (req_i.op)
          OP_CMPLT, OP_MIN: ctrl.cmp_kind = CMP_LT;
          OP_CMPLE:         ctrl.cmp_kind = CMP_LE;
          OP_MAX:           ctrl.cmp_kind = CMP_GT;
          default:          ctrl.cmp_kind = CMP_EQ;
        endcase
      end
      OP_SLL:  ctrl.shift_left = 1'b1;
      OP_PKBB, OP_PKBT, OP_PKTB, OP_PKTT: begin
        ctrl.is_pack  = 1'b1;
        ctrl.pack_sel = {req_i.op inside {OP_PKTB, OP_PKTT},
                         req_i.op inside {OP_PKBT, OP_PKTT}};
      end
      default: ;
    endcase

    // Rounding only matters for the add class
    if (ctrl.result_sel == RES_ADD) begin
      ctrl.rmode = req_i.rmode;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_valid_o <= 1'b0;
    end else begin
      ex_valid_o <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      ex_req_o <= '{ctrl: ctrl, op_a: req_i.op_a, op_b: req_i.op_b};
    end
  end

  // Paired ops must reach execute as halfword-lane work
  a_pair_16bit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && is_pair |=> ex_valid_o && !ex_req_o.ctrl.width8)
    else $error("paired add/sub issued with an 8-bit lane type");

endmodule

// ==== simd_alu_execute.sv ====
// Stage 2 of the SIMD ALU. Result and ov register on every strobe,
// and hold while no strobe arrives.

`timescale 1ns/1ps

module simd_alu_execute (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    ex_valid_i,
  input  simd_alu_pkg::exec_req_t ex_req_i,
  output logic                    resp_valid_o,
  output simd_alu_pkg::alu_resp_t resp_o
);
  import simd_alu_pkg::*;

  word_t sum, diff, cmp_res, minmax_res, shift_res;
  word_t result;
  logic  lane_ov, ov;

  simd_alu_addsub u_addsub (
    .ctrl_i (ex_req_i.ctrl),
    .op_a_i (ex_req_i.op_a),
    .op_b_i (ex_req_i.op_b),
    .sum_o  (sum),
    .diff_o (diff),
    .ov_o   (lane_ov)
  );

  simd_alu_compare u_compare (
    .ctrl_i   (ex_req_i.ctrl),
    .op_a_i   (ex_req_i.op_a),
    .op_b_i   (ex_req_i.op_b),
    .diff_i   (diff),
    .cmp_o    (cmp_res),
    .minmax_o (minmax_res)
  );

  simd_alu_shift u_shift (
    .ctrl_i   (ex_req_i.ctrl),
    .op_a_i   (ex_req_i.op_a),
    .op_b_i   (ex_req_i.op_b),
    .result_o (shift_res)
  );

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////
  always_comb begin
    unique case (ex_req_i.ctrl.result_sel)
      RES_ADD:    result = sum;
      RES_CMP:    result = cmp_res;
      RES_MINMAX: result = minmax_res;
      default:    result = shift_res;
    endcase
  end

  assign ov = lane_ov && (ex_req_i.ctrl.rmode == RM_SAT) &&
              (ex_req_i.ctrl.result_sel == RES_ADD);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= ex_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ex_valid_i) begin
      resp_o <= '{result: result, ov: ov};
    end
  end

  a_resp_valid_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(resp_valid_o))
    else $error("resp_valid_o unknown after reset");

endmodule

// ==== simd_alu_pkg.sv ====
// Shared types for the packed-SIMD ALU. Words are 32 bits, split into
// four byte lanes or two halfword lanes. Paired add/sub ops are only
// defined for 16-bit lane types.

package simd_alu_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [7:0]      byte_t;
  typedef logic [15:0]     half_t;
  typedef logic [3:0]      lane_mask_t;

  typedef enum logic [1:0] {
    U8,
    S8,
    U16,
    S16
  } lane_type_e;

  typedef enum logic [4:0] {
    OP_ADD,
    OP_SUB,
    OP_CRAS,
    OP_CRSA,
    OP_STAS,
    OP_STSA,
    OP_CMPEQ,
    OP_CMPLT,
    OP_CMPLE,
    OP_MIN,
    OP_MAX,
    OP_SLL,
    OP_SRL,
    OP_PKBB,
    OP_PKBT,
    OP_PKTB,
    OP_PKTT
  } alu_op_e;

  typedef enum logic [1:0] {
    RM_WRAP,
    RM_HALVE,
    RM_SAT
  } round_mode_e;

  typedef enum logic [1:0] {
    RES_ADD,
    RES_CMP,
    RES_MINMAX,
    RES_SHIFT_PACK
  } result_sel_e;

  // GT only serves MAX
  typedef enum logic [1:0] {
    CMP_EQ,
    CMP_LT,
    CMP_LE,
    CMP_GT
  } cmp_kind_e;

  typedef struct packed {
    alu_op_e     op;
    lane_type_e  ltype;
    round_mode_e rmode;
    word_t       op_a;
    word_t       op_b;
  } alu_req_t;

  typedef struct packed {
    logic        sub_lo;
    logic        sub_hi;
    logic        width8;
    logic        crossed;
    logic        is_signed;
    round_mode_e rmode;
    result_sel_e result_sel;
    cmp_kind_e   cmp_kind;
    logic        shift_left;
    logic        is_pack;
    logic [1:0]  pack_sel;   // {a top, b top}
  } exec_ctrl_t;

  typedef struct packed {
    exec_ctrl_t ctrl;
    word_t      op_a;
    word_t      op_b;
  } exec_req_t;

  typedef struct packed {
    word_t result;
    logic  ov;
  } alu_resp_t;

  // Saturation limits, unsigned minimum is zero
  localparam byte_t SAT_U8_MAX  = 8'hff;
  localparam byte_t SAT_S8_MIN  = 8'h80;
  localparam byte_t SAT_S8_MAX  = 8'h7f;
  localparam half_t SAT_U16_MAX = 16'hffff;
  localparam half_t SAT_S16_MIN = 16'h8000;
  localparam half_t SAT_S16_MAX = 16'h7fff;

endpackage

// ==== simd_alu_shift.sv ====
// Lane shifter and halfword packer. Amounts above the lane width
// are not possible since only b[3:0] or b[2:0] is used.

`timescale 1ns/1ps

module simd_alu_shift (
  input  simd_alu_pkg::exec_ctrl_t ctrl_i,
  input  simd_alu_pkg::word_t      op_a_i,
  input  simd_alu_pkg::word_t      op_b_i,
  output simd_alu_pkg::word_t      result_o
);
  import simd_alu_pkg::*;

  function automatic half_t shr16(half_t val, logic [3:0] amt, logic arith);
    half_t fill;
    fill = {16{arith & val[15]}} & ~(16'hffff >> amt);
    return (val >> amt) | fill;
  endfunction

  function automatic byte_t shr8(byte_t val, logic [2:0] amt, logic arith);
    byte_t fill;
    fill = {8{arith & val[7]}} & ~(8'hff >> amt);
    return (val >> amt) | fill;
  endfunction

  logic       arith;
  logic [3:0] amt;
  word_t      a_sel, shifted, pack_res;
  half_t      sh_hi, sh_lo;
  byte_t      sh_b2, sh_b0;

  // Left shift is a right shift on the bit-reversed word
  assign arith = ctrl_i.is_signed & ~ctrl_i.shift_left;
  assign amt   = ctrl_i.width8 ? {1'b0, op_b_i[2:0]} : op_b_i[3:0];
  assign a_sel = ctrl_i.shift_left ? {<<{op_a_i}} : op_a_i;

  assign sh_hi = shr16(a_sel[31:16], amt, arith);
  assign sh_lo = shr16(a_sel[15:0], amt, arith);
  assign sh_b2 = shr8(a_sel[23:16], amt[2:0], arith);
  assign sh_b0 = shr8(a_sel[7:0], amt[2:0], arith);

  // Upper bytes of the 16-bit shifters serve as the odd byte lanes
  assign shifted = ctrl_i.width8 ? {sh_hi[15:8], sh_b2, sh_lo[15:8], sh_b0} :
                                   {sh_hi, sh_lo};

  assign pack_res = {ctrl_i.pack_sel[1] ? op_a_i[31:16] : op_a_i[15:0],
                     ctrl_i.pack_sel[0] ? op_b_i[31:16] : op_b_i[15:0]};

  assign result_o = ctrl_i.is_pack    ? pack_res :
                    ctrl_i.shift_left ? {<<{shifted}} : shifted;

endmodule

// ==== simd_alu_tb_vectors.svh ====
// Directed vectors for the SIMD ALU testbench, one request per row.
// Columns: op, lane type, round mode, a, b, expected result, expected ov, test group.
// Groups: 1 wrap, 2 halve/sat, 3 pairs, 4 compare, 5 shift/pack

  localparam int num_vectors = 37;

  localparam vector_t vectors [num_vectors] = '{
    '{OP_ADD,  U8,  RM_WRAP,  32'h80ff01ff, 32'h80010101, 32'h00000200, 1'b0, 3'd1},
    '{OP_SUB,  S8,  RM_WRAP,  32'h00107f80, 32'h0120ff01, 32'hfff0807f, 1'b0, 3'd1},
    '{OP_ADD,  U16, RM_WRAP,  32'hffff00ff, 32'h00010001, 32'h00000100, 1'b0, 3'd1},
    '{OP_SUB,  S16, RM_WRAP,  32'h12340000, 32'h02340001, 32'h1000ffff, 1'b0, 3'd1},
    '{OP_SUB,  U8,  RM_WRAP,  32'h01000000, 32'h00010001, 32'h01ff00ff, 1'b0, 3'd1},
    '{OP_ADD,  S16, RM_WRAP,  32'h7fff8000, 32'h00018000, 32'h80000000, 1'b0, 3'd1},
    '{OP_ADD,  U8,  RM_HALVE, 32'hffff0100, 32'hff010101, 32'hff800100, 1'b0, 3'd2},
    '{OP_ADD,  S8,  RM_HALVE, 32'h7f80ff01, 32'h7f8001fe, 32'h7f8000ff, 1'b0, 3'd2},
    '{OP_SUB,  S16, RM_HALVE, 32'h80000003, 32'h7fff0000, 32'h80000001, 1'b0, 3'd2},
    '{OP_SUB,  U16, RM_HALVE, 32'h0004ffff, 32'h00020001, 32'h00017fff, 1'b0, 3'd2},
    '{OP_ADD,  U8,  RM_SAT,   32'hff801000, 32'h01801000, 32'hffff2000, 1'b1, 3'd2},
    '{OP_SUB,  U8,  RM_SAT,   32'h000510ff, 32'h01061000, 32'h000000ff, 1'b1, 3'd2},
    '{OP_ADD,  S8,  RM_SAT,   32'h7f8010f0, 32'h01ff10f0, 32'h7f8020e0, 1'b1, 3'd2},
    '{OP_SUB,  S16, RM_SAT,   32'h80007fff, 32'h0001ffff, 32'h80007fff, 1'b1, 3'd2},
    '{OP_ADD,  U16, RM_SAT,   32'h1234fff0, 32'h00010010, 32'h1235ffff, 1'b1, 3'd2},
    '{OP_SUB,  U16, RM_SAT,   32'h00100100, 32'h00100001, 32'h000000ff, 1'b0, 3'd2},
    '{OP_ADD,  S8,  RM_SAT,   32'h01020304, 32'h10203040, 32'h11223344, 1'b0, 3'd2},
    '{OP_CRAS, S16, RM_WRAP,  32'h10000200, 32'h00300004, 32'h100401d0, 1'b0, 3'd3},
    '{OP_CRSA, S16, RM_WRAP,  32'h10000200, 32'h00300004, 32'h0ffc0230, 1'b0, 3'd3},
    '{OP_STAS, S16, RM_WRAP,  32'h10000200, 32'h00300004, 32'h103001fc, 1'b0, 3'd3},
    '{OP_STSA, S16, RM_WRAP,  32'h10000200, 32'h00300004, 32'h0fd00204, 1'b0, 3'd3},
    '{OP_CRAS, U16, RM_WRAP,  32'hffff0000, 32'h00010001, 32'h0000ffff, 1'b0, 3'd3},
    '{OP_CMPEQ, U8, RM_WRAP,  32'h11223344, 32'h11003345, 32'hff00ff00, 1'b0, 3'd4},
    '{OP_CMPLT, U8, RM_WRAP,  32'h01ff8005, 32'h02017f05, 32'hff000000, 1'b0, 3'd4},
    '{OP_CMPLT, S8, RM_WRAP,  32'h01ff8005, 32'h02017f05, 32'hffffff00, 1'b0, 3'd4},
    '{OP_CMPLE, U16, RM_WRAP, 32'h80000005, 32'h7fff0005, 32'h0000ffff, 1'b0, 3'd4},
    '{OP_CMPLE, S16, RM_WRAP, 32'h80000005, 32'h7fff0005, 32'hffffffff, 1'b0, 3'd4},
    '{OP_CMPEQ, S16, RM_WRAP, 32'h12345678, 32'h13345678, 32'h0000ffff, 1'b0, 3'd4},
    '{OP_SLL,  U8,  RM_WRAP,  32'h8101ff0f, 32'h00000003, 32'h0808f878, 1'b0, 3'd5},
    '{OP_SRL,  U8,  RM_WRAP,  32'h8101ff0f, 32'h00000003, 32'h10001f01, 1'b0, 3'd5},
    '{OP_SRL,  S8,  RM_WRAP,  32'h8101ff0f, 32'h00000003, 32'hf000ff01, 1'b0, 3'd5},
    '{OP_SLL,  S16, RM_WRAP,  32'h800100ff, 32'h00000004, 32'h00100ff0, 1'b0, 3'd5},
    '{OP_SRL,  S16, RM_WRAP,  32'h80007ff0, 32'h000000f4, 32'hf80007ff, 1'b0, 3'd5},
    '{OP_PKBB, U16, RM_WRAP,  32'haaaabbbb, 32'hccccdddd, 32'hbbbbdddd, 1'b0, 3'd5},
    '{OP_PKBT, U16, RM_WRAP,  32'haaaabbbb, 32'hccccdddd, 32'hbbbbcccc, 1'b0, 3'd5},
    '{OP_PKTB, U16, RM_WRAP,  32'haaaabbbb, 32'hccccdddd, 32'haaaadddd, 1'b0, 3'd5},
    '{OP_PKTT, U16, RM_WRAP,  32'haaaabbbb, 32'hccccdddd, 32'haaaacccc, 1'b0, 3'd5}
  };

// ==== simd_alu_tb.sv ====
// Testbench for the SIMD ALU. Directed table rows, random MIN/MAX and a
// back-to-back burst. Every response must arrive exactly two cycles after
// its request and in request order.

`timescale 1ns/1ps

module simd_alu_tb;
  import simd_alu_pkg::*;

  typedef struct packed {
    alu_op_e     op;
    lane_type_e  ltype;
    round_mode_e rmode;
    word_t       a;
    word_t       b;
    word_t       result;
    logic        ov;
    logic [2:0]  grp;
  } vector_t;

  typedef struct packed {
    word_t       result;
    logic        ov;
    logic [31:0] cyc;
  } expect_t;

  `include "simd_alu_tb_vectors.svh"

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  alu_req_t    req;
  logic        resp_valid;
  alu_resp_t   resp;

  logic [31:0] cyc;
  logic [31:0] rng;
  expect_t     exp_q[$];
  int          checks;
  int          errors;
  int          tests;
  int          test_checks;
  int          test_errors;

  simd_alu u_simd_alu (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .resp_valid_o (resp_valid),
    .resp_o       (resp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 32'd1;
  end

  //////////////////////////////////////////////////
  // Reference helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Lane widened to 17 bits with its own signedness
  function automatic logic signed [16:0] lane_value(input word_t v, input int idx,
                                                    input bit wide, input bit sgn);
    logic [15:0] raw;
    logic        neg;
    if (wide) begin
      raw = v[16*idx +: 16];
      neg = sgn && raw[15];
    end else begin
      raw = {8'h00, v[8*idx +: 8]};
      neg = sgn && raw[7];
      if (neg) begin
        raw[15:8] = 8'hff;
      end
    end
    return $signed({neg, raw});
  endfunction

  // Each lane takes the smaller or larger of a and b
  function automatic word_t minmax_model(input bit is_max, input lane_type_e lt,
                                         input word_t a, input word_t b);
    word_t              r;
    bit                 wide;
    bit                 sgn;
    logic signed [16:0] x;
    logic signed [16:0] y;
    wide = (lt == U16) || (lt == S16);
    sgn  = (lt == S8) || (lt == S16);
    for (int j = 0; j < 4; j++) begin
      x = lane_value(a, wide ? j / 2 : j, wide, sgn);
      y = lane_value(b, wide ? j / 2 : j, wide, sgn);
      r[8*j +: 8] = (is_max ? (x > y) : (x < y)) ? a[8*j +: 8] : b[8*j +: 8];
    end
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Driving and checking
  //////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, want);
    end
  endtask

  // One strobe, called a small delay after a rising edge
  task automatic send(input alu_op_e op, input lane_type_e lt, input round_mode_e rm,
                      input word_t a, input word_t b, input word_t res, input logic ov);
    expect_t e;
    req_valid = 1'b1;
    req.op    = op;
    req.ltype = lt;
    req.rmode = rm;
    req.op_a  = a;
    req.op_b  = b;
    e.result  = res;
    e.ov      = ov;
    e.cyc     = cyc;
    exp_q.push_back(e);
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  // Missing responses count as errors and are dropped
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 10) begin
      @(posedge clk);
      #1;
      waited++;
    end
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("Timeout: %0d responses still missing after %0d cycles", exp_q.size(),
               waited);
      exp_q.delete();
    end
  endtask

  task automatic start_test();
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
             errors - test_errors);
  endtask

  // Responses are sampled mid-cycle
  always @(negedge clk) begin
    expect_t e;
    if (rst_n === 1'b1 && resp_valid === 1'b1) begin
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("Response at cycle %0d arrived with no request in flight", cyc);
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        check_value("resp_o.result", resp.result, e.result);
        check_value("resp_o.ov", 32'(resp.ov), 32'(e.ov));
        check_value("latency", cyc - e.cyc, 32'd2);
      end
    end
  end

  initial begin
    vector_t    v;
    word_t      a;
    word_t      b;
    lane_type_e lt;
    bit         is_max;
    string      names [5];
    names     = '{"wrap_addsub", "halve_sat", "pairs", "compare", "shift_pack"};
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    cyc       = '0;
    rng       = 32'h40e04da9;
    checks    = 0;
    errors    = 0;
    tests     = 0;

    start_test();
    repeat (5) begin
      @(posedge clk);
      #1;
      check_value("resp_valid_o", 32'(resp_valid), 32'd0);
    end
    rst_n = 1'b1;
    repeat (2) begin
      @(posedge clk);
      #1;
      check_value("resp_valid_o", 32'(resp_valid), 32'd0);
    end
    finish_test("reset");

    // Table rows by group, each group back to back
    for (int g = 1; g <= 5; g++) begin
      start_test();
      for (int i = 0; i < num_vectors; i++) begin
        v = vectors[i];
        if (v.grp == 3'(g)) begin
          send(v.op, v.ltype, v.rmode, v.a, v.b, v.result, v.ov);
        end
      end
      wait_drain();
      finish_test(names[g-1]);
    end

    start_test();
    for (int t = 0; t < 4; t++) begin
      lt = lane_type_e'(t);
      for (int n = 0; n < 200; n++) begin
        rng = xorshift32(rng);
        a   = rng;
        rng = xorshift32(rng);
        b   = rng;
        // Force some equal lanes
        if (b[31:29] == 3'b000) begin
          b[15:0] = a[15:0];
        end
        is_max = n[0];
        send(is_max ? OP_MAX : OP_MIN, lt, RM_WRAP, a, b, minmax_model(is_max, lt, a, b),
             1'b0);
      end
      wait_drain();
    end
    finish_test("minmax_rand");

    // Burst of 20 strobes, lane type rotates
    start_test();
    for (int n = 0; n < 20; n++) begin
      lt     = lane_type_e'(n % 4);
      rng    = xorshift32(rng);
      a      = rng;
      rng    = xorshift32(rng);
      b      = rng;
      is_max = rng[7];
      send(is_max ? OP_MAX : OP_MIN, lt, RM_WRAP, a, b, minmax_model(is_max, lt, a, b), 1'b0);
    end
    wait_drain();
    repeat (3) @(posedge clk);
    finish_test("back_to_back");

    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
